//--- vlog.f
source/xbus_io_pkg.sv
source/kbd_buffer.sv
source/mouse_tracker.sv
source/io_timers.sv
source/xbus_io.sv
source/io_board_top.sv
verif/io_board_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the i/o board testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module io_board_tb \
      -f vlog.f --Mdir obj_dir -o io_board_sim; then
   echo "verilator compile failed"
   exit 1
fi

if ! ./obj_dir/io_board_sim > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "simulation reported failures"
   exit 1
fi

echo "simulation passed"
exit 0

//--- verif/io_board_tb.sv
//----------------------------------------------------------
// xbus i/o board testbench with bus tasks, reference
// model, random mouse stimulus and checks
//----------------------------------------------------------
`default_nettype none

module io_board_tb;
   import xbus_io_pkg::*;

   logic        clk = 1'b0;
   logic        reset;
   logic [21:0] addr;
   logic [31:0] datain;
   logic        req;
   logic        write;
   logic [31:0] dataout;
   logic        ack;
   logic        decode;
   logic        interrupt;
   logic        kbd_valid;
   logic [31:0] kbd_code_in;
   logic        kbd_credit;
   logic [1:0]  mouse_qx;
   logic [1:0]  mouse_qy;
   logic [2:0]  mouse_buttons_in;

   // reference model state
   logic [11:0] m_x;
   logic [11:0] m_y;
   logic [31:0] m_key;
   logic        m_kfull;
   logic [3:0]  m_csr;
   logic        m_rdy_mouse;
   logic        m_rdy_clk;
   int          m_credits;

   logic [31:0] rng = 32'h7b140e71;
   int          cycles = 0;
   int          credit_pulses = 0;
   int          fail_count = 0;

   // pending checks queued by the test sequence for the compare process
   string       name_a [0:255];
   logic [31:0] exp_a [0:255];
   logic [31:0] act_a [0:255];
   logic [7:0]  wr_idx = 8'd0;
   logic [7:0]  rd_idx = 8'd0;
   int          checks = 0;
   int          errors = 0;

   io_board_top
   #(
      .US_DIV   (5),
      .HZ60_DIV (40)
   )
   dut0
   (
      .clk              (clk),
      .reset            (reset),
      .addr             (addr),
      .datain           (datain),
      .req              (req),
      .write            (write),
      .dataout          (dataout),
      .ack              (ack),
      .decode           (decode),
      .interrupt        (interrupt),
      .kbd_valid        (kbd_valid),
      .kbd_code_in      (kbd_code_in),
      .kbd_credit       (kbd_credit),
      .mouse_qx         (mouse_qx),
      .mouse_qy         (mouse_qy),
      .mouse_buttons_in (mouse_buttons_in)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (kbd_credit)
         credit_pulses <= credit_pulses + 1;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // quadrature order 00 01 11 10
   function automatic logic [1:0] gray_fwd(input logic [1:0] g);
      case (g)
         2'b00:   gray_fwd = 2'b01;
         2'b01:   gray_fwd = 2'b11;
         2'b11:   gray_fwd = 2'b10;
         default: gray_fwd = 2'b00;
      endcase
   endfunction

   function automatic logic [1:0] gray_rev(input logic [1:0] g);
      return gray_fwd(gray_fwd(gray_fwd(g)));
   endfunction

   // raw phases and buttons are simply what the testbench drives
   function automatic logic [31:0] expected_read(input logic [5:0] off);
      case (io_reg_e'(off))
         REG_KBD_LO:  expected_read = {16'd0, m_key[15:0]};
         REG_KBD_HI:  expected_read = {16'd0, m_key[31:16]};
         REG_MOUSE_Y: expected_read = {17'd0, mouse_buttons_in, m_y};
         REG_MOUSE_X: expected_read = {16'd0, mouse_qy, mouse_qx, m_x};
         REG_CSR:     expected_read = {24'd0, 1'b0, m_rdy_clk, m_kfull, m_rdy_mouse, m_csr};
         default:     expected_read = 32'd0;
      endcase
   endfunction

   function automatic logic expected_irq();
      return |(m_csr[2:0] & {m_rdy_clk, m_kfull, m_rdy_mouse});
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks = checks + 1;
      if (actual !== expected)
      begin
         errors = errors + 1;
         $display("[ERROR] %s, expected %h, actual %h", name, expected, actual);
      end
   endtask

   always @(posedge clk)
   begin
      while (rd_idx != wr_idx)
      begin
         check(name_a[rd_idx], exp_a[rd_idx], act_a[rd_idx]);
         rd_idx = rd_idx + 8'd1;
      end
   end

   task automatic expect_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      name_a[wr_idx] = name;
      exp_a[wr_idx]  = expected;
      act_a[wr_idx]  = actual;
      wr_idx         = wr_idx + 8'd1;
   endtask

   // inputs change a little after the rising edge
   task automatic next_cycle;
      @(posedge clk);
      #10;
   endtask

   task automatic apply_reset;
      reset = 1'b1;
      repeat (5) next_cycle;
      reset       = 1'b0;
      m_x         = 12'd0;
      m_y         = 12'd0;
      m_key       = 32'd0;
      m_kfull     = 1'b0;
      m_csr       = 4'd0;
      m_rdy_mouse = 1'b0;
      m_rdy_clk   = 1'b0;
      m_credits   = 1;
   endtask

   // hold req until ack then drop it and wait for ack to fall
   task automatic bus_access(input logic [5:0] off, input logic wr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      addr   = {io_base[21:6], off};
      write  = wr;
      datain = wdata;
      req    = 1'b1;
      rdata  = 32'd0;
      for (n = 0; n < 10 && !ack; n++)
         next_cycle;
      if (ack)
      begin
         rdata = dataout;
         expect_value("ack delay", 32'd2, n);
         expect_value("decode during access", 32'd1, 32'(decode));
      end
      else
      begin
         $display("no ack for offset %o within 10 cycles", off);
         fail_count++;
      end
      req   = 1'b0;
      write = 1'b0;
      for (n = 0; n < 10 && ack; n++)
         next_cycle;
      if (ack)
      begin
         $display("ack stayed high after req fell, offset %o", off);
         fail_count++;
      end
   endtask

   task automatic bus_read(input logic [5:0] off, output logic [31:0] rdata);
      bus_access(off, 1'b0, 32'd0, rdata);
   endtask

   task automatic bus_write(input logic [5:0] off, input logic [31:0] wdata);
      logic [31:0] unused_data;
      bus_access(off, 1'b1, wdata, unused_data);
   endtask

   // a read of the high keyboard half must return exactly one credit
   task automatic read_check(input logic [5:0] off, input string name);
      logic [31:0] d;
      int          p;
      p = credit_pulses;
      bus_read(off, d);
      expect_value(name, expected_read(off), d);
      expect_value({name, " credits"}, (off == REG_KBD_HI) ? 32'd1 : 32'd0,
                   credit_pulses - p);
      m_credits = m_credits + (credit_pulses - p);
      if (off == REG_KBD_HI)
         m_kfull = 1'b0;
      if (off == REG_MOUSE_Y)
         m_rdy_mouse = 1'b0;
   endtask

   task automatic send_key(input logic [31:0] code);
      if (m_credits < 1)
      begin
         $display("keyboard source holds no credit for code %h", code);
         fail_count++;
      end
      else
      begin
         kbd_code_in = code;
         kbd_valid   = 1'b1;
         next_cycle;
         kbd_valid   = 1'b0;
         m_credits   = m_credits - 1;
         m_key       = code;
         m_kfull     = 1'b1;
      end
   endtask

   task automatic key_round;
      rng = xorshift(rng);
      send_key(rng);
      read_check(REG_CSR, "kbd ready");
      read_check(REG_KBD_LO, "kbd low");
      read_check(REG_KBD_HI, "kbd high");
      read_check(REG_CSR, "kbd ready cleared");
   endtask

   // one legal step per 4 cycles with an occasional button change
   task automatic mouse_steps(input int count);
      logic fwd;
      for (int i = 0; i < count; i++)
      begin
         rng = xorshift(rng);
         fwd = rng[1];
         if (rng[0])
         begin
            mouse_qx = fwd ? gray_fwd(mouse_qx) : gray_rev(mouse_qx);
            m_x      = fwd ? m_x + 12'd1 : m_x - 12'd1;
         end
         else
         begin
            mouse_qy = fwd ? gray_fwd(mouse_qy) : gray_rev(mouse_qy);
            m_y      = fwd ? m_y + 12'd1 : m_y - 12'd1;
         end
         if (rng[4:3] == 2'b00)
            mouse_buttons_in = rng[7:5];
         m_rdy_mouse = 1'b1;
         repeat (4) next_cycle;
      end
      repeat (4) next_cycle;
   endtask

   initial
   begin
      logic [31:0] d0;
      logic [31:0] d1;
      int          c0;
      int          n;
      logic        seen;

      reset            = 1'b1;
      addr             = 22'd0;
      datain           = 32'd0;
      req              = 1'b0;
      write            = 1'b0;
      kbd_valid        = 1'b0;
      kbd_code_in      = 32'd0;
      mouse_qx         = 2'b00;
      mouse_qy         = 2'b00;
      mouse_buttons_in = 3'b000;
      apply_reset;

      expect_value("reset ack", 32'd0, 32'(ack));
      expect_value("reset decode", 32'd0, 32'(decode));
      expect_value("reset interrupt", 32'd0, 32'(interrupt));
      expect_value("reset credit", 32'd0, 32'(kbd_credit));
      read_check(REG_CSR, "reset csr");
      bus_read(REG_HZ60, d0);
      expect_value("reset hz60", 32'd0, d0);

      // that read started the 60 Hz clock
      apply_reset;

      // second round runs on the returned credit
      repeat (2) key_round;

      mouse_steps(40);
      read_check(REG_CSR, "mouse ready");
      read_check(REG_MOUSE_X, "mouse x");
      read_check(REG_MOUSE_Y, "mouse y");
      read_check(REG_CSR, "mouse ready cleared");

      bus_write(REG_CSR, 32'h0000_000b);
      m_csr = 4'hb;
      read_check(REG_CSR, "csr readback");
      bus_write(REG_CSR, 32'h0000_0003);
      m_csr = 4'h3;
      expect_value("irq idle", 32'(expected_irq()), 32'(interrupt));
      rng = xorshift(rng);
      send_key(rng);
      expect_value("irq kbd", 32'(expected_irq()), 32'(interrupt));
      read_check(REG_KBD_HI, "kbd high irq");
      expect_value("irq kbd cleared", 32'(expected_irq()), 32'(interrupt));
      mouse_steps(3);
      expect_value("irq mouse", 32'(expected_irq()), 32'(interrupt));
      read_check(REG_MOUSE_Y, "mouse y irq");
      expect_value("irq mouse cleared", 32'(expected_irq()), 32'(interrupt));

      // microsecond clock against the cycle count
      bus_read(REG_USEC_LO, d0);
      c0 = cycles;
      rng = xorshift(rng);
      repeat (20 + rng[5:0]) next_cycle;
      bus_read(REG_USEC_LO, d1);
      c0 = cycles - c0;
      n  = int'(d1 - d0);
      if (n < c0 / 5 - 1 || n > c0 / 5 + 1)
         expect_value("usec delta", c0 / 5, d1 - d0);

      bus_write(REG_CSR, 32'h0000_0004);
      m_csr = 4'h4;
      bus_read(REG_HZ60, d0);
      expect_value("hz60 before start", 32'd0, d0);
      for (n = 0; n < 200 && !interrupt; n++)
         next_cycle;
      if (!interrupt)
      begin
         $display("60 Hz interrupt did not rise within 200 cycles");
         fail_count++;
      end
      m_rdy_clk = 1'b1;
      read_check(REG_CSR, "clock ready");
      bus_read(REG_HZ60, d0);
      m_rdy_clk = 1'b0;
      expect_value("hz60 running", 32'd1, 32'(d0 != 32'd0));
      expect_value("irq clock cleared", 32'(expected_irq()), 32'(interrupt));

      read_check(REG_BEEP, "beep reads zero");
      read_check(6'o77, "unmapped reads zero");

      // first word past the window
      addr  = io_base + 22'o100;
      write = 1'b0;
      req   = 1'b1;
      seen  = 1'b0;
      for (n = 0; n < 6; n++)
      begin
         next_cycle;
         seen = seen | decode | ack;
      end
      req = 1'b0;
      expect_value("outside window", 32'd0, 32'(seen));

      repeat (2) next_cycle;
      $display("checks %0d, mismatches %0d, other failures %0d",
               checks, errors, fail_count);
      if (errors == 0 && fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/io_board_top.sv
//----------------------------------------------------------
// i/o board top level: bus slave, keyboard buffer, mouse
// tracker and timers
//----------------------------------------------------------
`default_nettype none

module io_board_top
#(
   parameter int unsigned US_DIV   = xbus_io_pkg::us_div_default,
   parameter int unsigned HZ60_DIV = xbus_io_pkg::hz60_div_default
)
(
   input  wire         clk,
   input  wire         reset,
   input  wire  [21:0] addr,
   input  wire  [31:0] datain,
   input  wire         req,
   input  wire         write,
   output logic [31:0] dataout,
   output logic        ack,
   output logic        decode,
   output logic        interrupt,
   input  wire         kbd_valid,
   input  wire  [31:0] kbd_code_in,
   output logic        kbd_credit,
   input  wire  [1:0]  mouse_qx,
   input  wire  [1:0]  mouse_qy,
   input  wire  [2:0]  mouse_buttons_in
);
   import xbus_io_pkg::*;

   logic [31:0]            kbd_code;
   logic                   kbd_full;
   logic                   kbd_pop;
   logic [mouse_pos_w-1:0] mouse_x;
   logic [mouse_pos_w-1:0] mouse_y;
   logic [1:0]             mouse_raw_x;
   logic [1:0]             mouse_raw_y;
   logic [2:0]             mouse_buttons;
   logic                   mouse_moved;
   logic [31:0]            us_clock;
   logic [31:0]            hz60_clock;
   logic                   hz60_fire;
   logic                   hz60_start;

   xbus_io xbus_io0
   (
      .clk           (clk),
      .reset         (reset),
      .addr          (addr),
      .datain        (datain),
      .req           (req),
      .write         (write),
      .kbd_code      (kbd_code),
      .kbd_full      (kbd_full),
      .mouse_x       (mouse_x),
      .mouse_y       (mouse_y),
      .mouse_raw_x   (mouse_raw_x),
      .mouse_raw_y   (mouse_raw_y),
      .mouse_buttons (mouse_buttons),
      .mouse_moved   (mouse_moved),
      .us_clock      (us_clock),
      .hz60_clock    (hz60_clock),
      .hz60_fire     (hz60_fire),
      .dataout       (dataout),
      .ack           (ack),
      .decode        (decode),
      .interrupt     (interrupt),
      .kbd_pop       (kbd_pop),
      .hz60_start    (hz60_start)
   );

   kbd_buffer kbd_buffer0
   (
      .clk         (clk),
      .reset       (reset),
      .kbd_valid   (kbd_valid),
      .kbd_code_in (kbd_code_in),
      .kbd_pop     (kbd_pop),
      .kbd_code    (kbd_code),
      .kbd_full    (kbd_full),
      .kbd_credit  (kbd_credit)
   );

   mouse_tracker mouse_tracker0
   (
      .clk              (clk),
      .reset            (reset),
      .mouse_qx         (mouse_qx),
      .mouse_qy         (mouse_qy),
      .mouse_buttons_in (mouse_buttons_in),
      .mouse_x          (mouse_x),
      .mouse_y          (mouse_y),
      .mouse_raw_x      (mouse_raw_x),
      .mouse_raw_y      (mouse_raw_y),
      .mouse_buttons    (mouse_buttons),
      .mouse_moved      (mouse_moved)
   );

   io_timers
   #(
      .US_DIV   (US_DIV),
      .HZ60_DIV (HZ60_DIV)
   )
   io_timers0
   (
      .clk        (clk),
      .reset      (reset),
      .hz60_start (hz60_start),
      .us_clock   (us_clock),
      .hz60_clock (hz60_clock),
      .hz60_fire  (hz60_fire)
   );

endmodule

`default_nettype wire

//--- source/xbus_io.sv
//----------------------------------------------------------
// xbus slave for the i/o board: decode, ack delay, read mux,
// csr, ready flags and interrupt
//----------------------------------------------------------
`default_nettype none

module xbus_io
(
   input  wire                                 clk,
   input  wire                                 reset,
   input  wire  [21:0]                         addr,
   input  wire  [31:0]                         datain,
   input  wire                                 req,
   input  wire                                 write,
   input  wire  [31:0]                         kbd_code,
   input  wire                                 kbd_full,
   input  wire  [xbus_io_pkg::mouse_pos_w-1:0] mouse_x,
   input  wire  [xbus_io_pkg::mouse_pos_w-1:0] mouse_y,
   input  wire  [1:0]                          mouse_raw_x,
   input  wire  [1:0]                          mouse_raw_y,
   input  wire  [2:0]                          mouse_buttons,
   input  wire                                 mouse_moved,
   input  wire  [31:0]                         us_clock,
   input  wire  [31:0]                         hz60_clock,
   input  wire                                 hz60_fire,
   output logic [31:0]                         dataout,
   output logic                                ack,
   output logic                                decode,
   output logic                                interrupt,
   output logic                                kbd_pop,
   output logic                                hz60_start
);
   import xbus_io_pkg::*;

   logic [1:0]  ack_dly;
   logic        in_progress;
   logic        strobe;
   logic        rd_strobe;
   logic        wr_strobe;
   io_reg_e     offset;
   logic [31:0] rd_data;
   logic [3:0]  csr;
   logic        rdy_mouse;
   logic        rdy_clk;
   logic [3:0]  rdy;

   assign decode = req & (addr[21:6] == io_base[21:6]);
   assign ack    = ack_dly[1];
   assign offset = io_reg_e'(addr[5:0]);

   // first decoded cycle of a request
   assign strobe    = decode & ~in_progress;
   assign rd_strobe = strobe & ~write;
   assign wr_strobe = strobe & write;

   assign kbd_pop    = rd_strobe & (offset == REG_KBD_HI);
   assign hz60_start = rd_strobe & (offset == REG_HZ60);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_dly     <= 2'b00;
         in_progress <= 1'b0;
      end
      else
      begin
         ack_dly <= {ack_dly[0], decode};

         // held until the master drops req
         if (!req)
            in_progress <= 1'b0;
         else if (decode)
            in_progress <= 1'b1;
      end
   end

   // read mux, unmapped offsets return zero
   always_comb
   begin
      case (offset)
         REG_KBD_LO:  rd_data = {16'd0, kbd_code[15:0]};
         REG_KBD_HI:  rd_data = {16'd0, kbd_code[31:16]};
         REG_MOUSE_Y: rd_data = 32'({mouse_buttons, mouse_y});
         REG_MOUSE_X: rd_data = 32'({mouse_raw_y, mouse_raw_x, mouse_x});
         REG_CSR:     rd_data = {24'd0, rdy, csr};
         REG_USEC_LO: rd_data = {16'd0, us_clock[15:0]};
         REG_USEC_HI: rd_data = {16'd0, us_clock[31:16]};
         REG_HZ60:    rd_data = hz60_clock;
         default:     rd_data = 32'd0;
      endcase
   end

   // sampled every decoded cycle, stable by the time ack rises
   always_ff @(posedge clk)
   begin
      if (decode)
      begin
         dataout <= rd_data;
      end
   end

   // csr and ready flags; a set beats a clear in the same cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr       <= 4'd0;
         rdy_mouse <= 1'b0;
         rdy_clk   <= 1'b0;
      end
      else
      begin
         if (wr_strobe && offset == REG_CSR)
            csr <= datain[3:0];

         if (mouse_moved)
            rdy_mouse <= 1'b1;
         else if (rd_strobe && offset == REG_MOUSE_Y)
            rdy_mouse <= 1'b0;

         if (hz60_fire)
            rdy_clk <= 1'b1;
         else if (rd_strobe && offset == REG_HZ60)
            rdy_clk <= 1'b0;
      end
   end

   // keyboard flag lives in the buffer itself
   always_comb
   begin
      rdy = 4'd0;
      rdy[csr_mouse_ie] = rdy_mouse;
      rdy[csr_kbd_ie]   = kbd_full;
      rdy[csr_clk_ie]   = rdy_clk;
   end

   assign interrupt = |(csr & rdy);

endmodule

`default_nettype wire

//--- source/io_timers.sv
//----------------------------------------------------------
// free-running microsecond clock and start-on-read 60 Hz clock
//----------------------------------------------------------
`default_nettype none

module io_timers
#(
   parameter int unsigned US_DIV   = xbus_io_pkg::us_div_default,
   parameter int unsigned HZ60_DIV = xbus_io_pkg::hz60_div_default
)
(
   input  wire         clk,
   input  wire         reset,
   input  wire         hz60_start,
   output logic [31:0] us_clock,
   output logic [31:0] hz60_clock,
   output logic        hz60_fire
);
   import xbus_io_pkg::*;

   // both prescalers share one width, the 60 Hz one being the larger
   logic [hz60_cnt_w-1:0] us_pre;
   logic [hz60_cnt_w-1:0] hz60_pre;
   logic                  hz60_en;
   logic                  us_wrap;
   logic                  hz60_wrap;

   assign us_wrap   = (us_pre == hz60_cnt_w'(US_DIV - 1));
   assign hz60_wrap = (hz60_pre == hz60_cnt_w'(HZ60_DIV - 1));

   // microsecond clock, runs from reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         us_pre   <= '0;
         us_clock <= 32'd0;
      end
      else if (us_wrap)
      begin
         us_pre   <= '0;
         us_clock <= us_clock + 32'd1;
      end
      else
      begin
         us_pre <= us_pre + 1'b1;
      end
   end

   // 60 Hz clock, idle until the first read
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hz60_en    <= 1'b0;
         hz60_pre   <= '0;
         hz60_clock <= 32'd0;
         hz60_fire  <= 1'b0;
      end
      else
      begin
         if (hz60_start)
            hz60_en <= 1'b1;

         hz60_fire <= 1'b0;
         if (hz60_en)
         begin
            if (hz60_wrap)
            begin
               hz60_pre   <= '0;
               hz60_clock <= hz60_clock + 32'd1;
               hz60_fire  <= 1'b1;
            end
            else
            begin
               hz60_pre <= hz60_pre + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/mouse_tracker.sv
//----------------------------------------------------------
// quadrature mouse tracker: synchronizers, x/y up/down
// counters, button capture and movement strobe
//----------------------------------------------------------
`default_nettype none

module mouse_tracker
(
   input  wire                               clk,
   input  wire                               reset,
   input  wire  [1:0]                        mouse_qx,
   input  wire  [1:0]                        mouse_qy,
   input  wire  [2:0]                        mouse_buttons_in,
   output logic [xbus_io_pkg::mouse_pos_w-1:0] mouse_x,
   output logic [xbus_io_pkg::mouse_pos_w-1:0] mouse_y,
   output logic [1:0]                        mouse_raw_x,
   output logic [1:0]                        mouse_raw_y,
   output logic [2:0]                        mouse_buttons,
   output logic                              mouse_moved
);
   import xbus_io_pkg::*;

   logic [1:0]             qx_meta;
   logic [1:0]             qx_sync;
   logic [1:0]             qy_meta;
   logic [1:0]             qy_sync;
   logic [2:0]             btn_meta;
   logic [2:0]             btn_sync;
   logic [mouse_pos_w-1:0] next_x;
   logic [mouse_pos_w-1:0] next_y;

   // forward step of the gray sequence 00 01 11 10
   function automatic logic [1:0] gray_next
   (
      input logic [1:0] g
   );
      case (g)
         2'b00:   gray_next = 2'b01;
         2'b01:   gray_next = 2'b11;
         2'b11:   gray_next = 2'b10;
         default: gray_next = 2'b00;
      endcase
   endfunction

   // count one step either way; a double-bit jump is dropped
   function automatic logic [mouse_pos_w-1:0] quad_count
   (
      input logic [1:0]             prev,
      input logic [1:0]             cur,
      input logic [mouse_pos_w-1:0] count
   );
      if (cur == gray_next(prev))
         quad_count = count + 1'b1;
      else if (prev == gray_next(cur))
         quad_count = count - 1'b1;
      else
         quad_count = count;
   endfunction

   // raw outputs hold the last sampled phase
   assign next_x = quad_count(mouse_raw_x, qx_sync, mouse_x);
   assign next_y = quad_count(mouse_raw_y, qy_sync, mouse_y);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         qx_meta       <= 2'b00;
         qx_sync       <= 2'b00;
         qy_meta       <= 2'b00;
         qy_sync       <= 2'b00;
         btn_meta      <= 3'b000;
         btn_sync      <= 3'b000;
         mouse_raw_x   <= 2'b00;
         mouse_raw_y   <= 2'b00;
         mouse_x       <= '0;
         mouse_y       <= '0;
         mouse_buttons <= 3'b000;
         mouse_moved   <= 1'b0;
      end
      else
      begin
         qx_meta  <= mouse_qx;
         qx_sync  <= qx_meta;
         qy_meta  <= mouse_qy;
         qy_sync  <= qy_meta;
         btn_meta <= mouse_buttons_in;
         btn_sync <= btn_meta;

         mouse_raw_x   <= qx_sync;
         mouse_raw_y   <= qy_sync;
         mouse_x       <= next_x;
         mouse_y       <= next_y;
         mouse_buttons <= btn_sync;

         mouse_moved <= (next_x != mouse_x) | (next_y != mouse_y) |
                        (btn_sync != mouse_buttons);
      end
   end

endmodule

`default_nettype wire

//--- source/kbd_buffer.sv
//----------------------------------------------------------
// one-entry keyboard scan-code buffer with credit return
//----------------------------------------------------------
`default_nettype none

module kbd_buffer
(
   input  wire         clk,
   input  wire         reset,
   input  wire         kbd_valid,
   input  wire  [31:0] kbd_code_in,
   input  wire         kbd_pop,
   output logic [31:0] kbd_code,
   output logic        kbd_full,
   output logic        kbd_credit
);

   // scan code holding register
   always_ff @(posedge clk)
   begin
      if (kbd_valid)
      begin
         kbd_code <= kbd_code_in;
      end
   end

   // a new code wins over a pop in the same cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         kbd_full   <= 1'b0;
         kbd_credit <= 1'b0;
      end
      else
      begin
         if (kbd_valid)
            kbd_full <= 1'b1;
         else if (kbd_pop)
            kbd_full <= 1'b0;

         // credit goes back one cycle after the pop
         kbd_credit <= kbd_pop;
      end
   end

endmodule

`default_nettype wire

//--- source/xbus_io_pkg.sv
//----------------------------------------------------------
// register map, csr bit positions and default clock
// divisors for the xbus i/o board
//----------------------------------------------------------
`default_nettype none

package xbus_io_pkg;

   // 64-word window, matched on address bits 21..6
   localparam logic [21:0] io_base = 22'o17772000;

   // word offsets inside the window
   typedef enum logic [5:0]
   {
      REG_KBD_LO  = 6'o40,
      REG_KBD_HI  = 6'o41,
      REG_MOUSE_Y = 6'o42,
      REG_MOUSE_X = 6'o43,
      REG_BEEP    = 6'o44,
      REG_CSR     = 6'o45,
      REG_USEC_LO = 6'o50,
      REG_USEC_HI = 6'o51,
      REG_HZ60    = 6'o52
   } io_reg_e;

   // interrupt enable bits, same positions as the ready flags
   localparam int csr_mouse_ie = 0;
   localparam int csr_kbd_ie   = 1;
   localparam int csr_clk_ie   = 2;

   // 50 MHz system clock
   localparam int unsigned us_div_default   = 50;
   localparam int unsigned hz60_div_default = 833333;

   // wide enough for the 60 Hz divisor
   localparam int hz60_cnt_w = 20;

   localparam int mouse_pos_w = 12;

endpackage

`default_nettype wire
